/* Makefile */
TOP = wb_subsys_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

/* hdl/wb_arbiter.sv */
// ------------------------------
// Round-robin arbiter
// Grants one requester and holds it until its request drops
// ------------------------------
`timescale 1ns/100ps

module wb_arbiter #(
	parameter int N_REQ = 3
) (
	input  logic                     clk,
	input  logic                     rstn,
	input  logic [N_REQ-1:0]         req_i,
	output logic                     gnt_o,
	output logic [$clog2(N_REQ)-1:0] gnt_id_o
);

	logic                     pick_vld;
	logic [$clog2(N_REQ)-1:0] pick_id;

	// gnt_id_o also serves as the last grant for the rotation
	always_comb begin
		pick_vld = 1'b0;
		pick_id  = '0;
		// Lowest requester, used when none sits above the last grant
		for (int i = N_REQ - 1; i >= 0; i--) begin
			if (req_i[i]) begin
				pick_vld = 1'b1;
				pick_id  = i[$clog2(N_REQ)-1:0];
			end
		end
		// First requester above the last grant wins
		for (int i = N_REQ - 1; i >= 0; i--) begin
			if (req_i[i] && (i > int'(gnt_id_o))) begin
				pick_id = i[$clog2(N_REQ)-1:0];
			end
		end
	end

	// gnt_o is the state: low is idle, high is granted
	always_ff @(posedge clk) begin
		if (!rstn) begin
			gnt_o    <= 1'b0;
			// All ones so the first grant after reset wraps to requester 0
			gnt_id_o <= '1;
		end else if (!gnt_o) begin
			if (pick_vld) begin
				gnt_o    <= 1'b1;
				gnt_id_o <= pick_id;
			end
		end else if (!req_i[gnt_id_o]) begin
			gnt_o <= 1'b0;
		end
	end

endmodule

/* hdl/wb_crossbar.sv */
// ------------------------------
// Wishbone crossbar, three masters to two slaves
// Target tracking, address decode, arbitration
// Request and response muxes, decode-error target
// ------------------------------
`timescale 1ns/100ps

module wb_crossbar (
	input  logic                         clk,
	input  logic                         rstn,
	input  logic [wb_pkg::WB_ADDR_W-1:0] m_adr_i   [wb_pkg::N_MASTERS],
	input  logic [wb_pkg::WB_DATA_W-1:0] m_dat_w_i [wb_pkg::N_MASTERS],
	input  logic [wb_pkg::WB_SEL_W-1:0]  m_sel_i   [wb_pkg::N_MASTERS],
	input  logic                         m_we_i    [wb_pkg::N_MASTERS],
	input  logic                         m_cyc_i   [wb_pkg::N_MASTERS],
	input  logic                         m_stb_i   [wb_pkg::N_MASTERS],
	output logic [wb_pkg::WB_DATA_W-1:0] m_dat_r_o [wb_pkg::N_MASTERS],
	output logic                         m_ack_o   [wb_pkg::N_MASTERS],
	output logic                         m_err_o   [wb_pkg::N_MASTERS],
	wb_if.master                         s0,
	wb_if.master                         s1
);

	// Port 0 is the SRAM, port 1 the register block, port 2 the decode-error target
	logic                                 tgt_vld     [wb_pkg::N_MASTERS];
	logic [1:0]                           tgt_port    [wb_pkg::N_MASTERS];
	logic [wb_pkg::N_MASTERS-1:0]         port_req    [wb_pkg::N_SLAVES+1];
	logic [wb_pkg::N_SLAVES:0]            port_gnt;
	logic [$clog2(wb_pkg::N_MASTERS)-1:0] port_gnt_id [wb_pkg::N_SLAVES+1];

	logic [wb_pkg::WB_ADDR_W-1:0] p_adr   [wb_pkg::N_SLAVES+1];
	logic [wb_pkg::WB_DATA_W-1:0] p_dat_w [wb_pkg::N_SLAVES+1];
	logic [wb_pkg::WB_SEL_W-1:0]  p_sel   [wb_pkg::N_SLAVES+1];
	logic                         p_we    [wb_pkg::N_SLAVES+1];
	logic                         p_cyc   [wb_pkg::N_SLAVES+1];
	logic                         p_stb   [wb_pkg::N_SLAVES+1];
	logic [wb_pkg::WB_DATA_W-1:0] p_dat_r [wb_pkg::N_SLAVES+1];
	logic                         p_ack   [wb_pkg::N_SLAVES+1];
	logic                         p_err   [wb_pkg::N_SLAVES+1];

	logic derr_err;

	function automatic logic [1:0] decode_port(input logic [wb_pkg::WB_ADDR_W-1:0] adr);
		wb_pkg::wb_addr_u a;
		a.raw = adr;
		if (a.fields.region == wb_pkg::REGION_SRAM) begin
			return 2'd0;
		end
		if (a.fields.region == wb_pkg::REGION_REGS) begin
			return 2'd1;
		end
		return 2'd2;
	endfunction

	// Target is latched on a new strobe and dropped after the response
	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int m = 0; m < wb_pkg::N_MASTERS; m++) begin
				tgt_vld[m]  <= 1'b0;
				tgt_port[m] <= '0;
			end
		end else begin
			for (int m = 0; m < wb_pkg::N_MASTERS; m++) begin
				if (!tgt_vld[m]) begin
					if (m_cyc_i[m] && m_stb_i[m]) begin
						tgt_vld[m]  <= 1'b1;
						tgt_port[m] <= decode_port(m_adr_i[m]);
					end
				end else if (m_ack_o[m] || m_err_o[m]) begin
					tgt_vld[m] <= 1'b0;
				end
			end
		end
	end

	for (genvar p = 0; p <= wb_pkg::N_SLAVES; p++) begin : g_port
		for (genvar m = 0; m < wb_pkg::N_MASTERS; m++) begin : g_req
			assign port_req[p][m] = tgt_vld[m] && (tgt_port[m] == 2'(p));
		end

		wb_arbiter #(
			.N_REQ (wb_pkg::N_MASTERS)
		) u_arb (
			.clk      (clk),
			.rstn     (rstn),
			.req_i    (port_req[p]),
			.gnt_o    (port_gnt[p]),
			.gnt_id_o (port_gnt_id[p])
		);
	end

	// Granted master drives each port, an idle port sees zeros
	always_comb begin
		for (int p = 0; p <= wb_pkg::N_SLAVES; p++) begin
			p_adr[p]   = '0;
			p_dat_w[p] = '0;
			p_sel[p]   = '0;
			p_we[p]    = 1'b0;
			p_cyc[p]   = 1'b0;
			p_stb[p]   = 1'b0;
			if (port_gnt[p]) begin
				p_adr[p]   = m_adr_i[port_gnt_id[p]];
				p_dat_w[p] = m_dat_w_i[port_gnt_id[p]];
				p_sel[p]   = m_sel_i[port_gnt_id[p]];
				p_we[p]    = m_we_i[port_gnt_id[p]];
				p_cyc[p]   = m_cyc_i[port_gnt_id[p]];
				p_stb[p]   = m_stb_i[port_gnt_id[p]];
			end
		end
	end

	// A response only returns to the master that holds the grant
	always_comb begin
		for (int m = 0; m < wb_pkg::N_MASTERS; m++) begin
			m_dat_r_o[m] = '0;
			m_ack_o[m]   = 1'b0;
			m_err_o[m]   = 1'b0;
			if (tgt_vld[m] && port_gnt[tgt_port[m]] &&
					(port_gnt_id[tgt_port[m]] == 2'(m))) begin
				m_dat_r_o[m] = p_dat_r[tgt_port[m]];
				m_ack_o[m]   = p_ack[tgt_port[m]];
				m_err_o[m]   = p_err[tgt_port[m]];
			end
		end
	end

	assign s0.adr   = p_adr[0];
	assign s0.dat_w = p_dat_w[0];
	assign s0.sel   = p_sel[0];
	assign s0.we    = p_we[0];
	assign s0.cyc   = p_cyc[0];
	assign s0.stb   = p_stb[0];
	assign s1.adr   = p_adr[1];
	assign s1.dat_w = p_dat_w[1];
	assign s1.sel   = p_sel[1];
	assign s1.we    = p_we[1];
	assign s1.cyc   = p_cyc[1];
	assign s1.stb   = p_stb[1];

	assign p_dat_r[0] = s0.dat_r;
	assign p_ack[0]   = s0.ack;
	assign p_err[0]   = s0.err;
	assign p_dat_r[1] = s1.dat_r;
	assign p_ack[1]   = s1.ack;
	assign p_err[1]   = s1.err;

	// Decode-error target answers ERR one cycle after it sees the strobe
	assign p_dat_r[wb_pkg::N_SLAVES] = '0;
	assign p_ack[wb_pkg::N_SLAVES]   = 1'b0;
	assign p_err[wb_pkg::N_SLAVES]   = derr_err;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			derr_err <= 1'b0;
		end else begin
			derr_err <= p_cyc[wb_pkg::N_SLAVES] && p_stb[wb_pkg::N_SLAVES] && !derr_err;
		end
	end

endmodule

/* hdl/wb_ctrl_regs.sv */
// ------------------------------
// Control register block
// Four registers with wait states before acknowledge
// ------------------------------
`timescale 1ns/100ps

module wb_ctrl_regs (
	input  logic  clk,
	input  logic  rstn,
	wb_if.slave   bus
);

	logic [3:0][wb_pkg::WB_DATA_W-1:0] regs;
	logic [wb_pkg::REG_WAIT_W-1:0]     wcnt;
	wb_pkg::wb_addr_u                  adr_w;
	logic [1:0]                        ridx;
	logic                              mapped;

	assign adr_w.raw = bus.adr;
	assign ridx      = adr_w.fields.word_idx[1:0];
	// Only indexes 0 to 3 exist, anything higher is left hanging
	assign mapped    = (adr_w.fields.word_idx[25:2] == '0);

	assign bus.err = 1'b0;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			regs    <= wb_pkg::CTRL_RESET;
			wcnt    <= '0;
			bus.ack <= 1'b0;
		end else begin
			bus.ack <= 1'b0;
			if (!(bus.cyc && bus.stb) || bus.ack) begin
				wcnt <= '0;
			end else if (wcnt != wb_pkg::REG_WAIT) begin
				wcnt <= wcnt + 1'b1;
			end else if (mapped) begin
				bus.ack <= 1'b1;
				if (bus.we) begin
					for (int b = 0; b < wb_pkg::WB_SEL_W; b++) begin
						if (bus.sel[b]) begin
							regs[ridx][8*b +: 8] <= bus.dat_w[8*b +: 8];
						end
					end
				end
			end
		end
	end

	// Read data follows the strobe, valid when ack rises
	always_ff @(posedge clk) begin
		if (bus.cyc && bus.stb) begin
			bus.dat_r <= regs[ridx];
		end
	end

endmodule

/* hdl/wb_if.sv */
// ------------------------------
// Wishbone classic link
// Master and slave modports
// ------------------------------
`timescale 1ns/100ps

interface wb_if;

	// Request side
	logic [wb_pkg::WB_ADDR_W-1:0] adr;
	logic [wb_pkg::WB_DATA_W-1:0] dat_w;
	logic [wb_pkg::WB_SEL_W-1:0]  sel;
	logic                         we;
	logic                         cyc;
	logic                         stb;

	// Response side
	logic [wb_pkg::WB_DATA_W-1:0] dat_r;
	logic                         ack;
	logic                         err;

	modport master (
		output adr, dat_w, sel, we, cyc, stb,
		input  dat_r, ack, err
	);

	modport slave (
		input  adr, dat_w, sel, we, cyc, stb,
		output dat_r, ack, err
	);

endinterface

/* hdl/wb_link_watchdog.sv */
// ------------------------------
// Slave link watchdog
// Ends a cycle with ERR when no acknowledge comes in time
// ------------------------------
`timescale 1ns/100ps

module wb_link_watchdog (
	input  logic  clk,
	input  logic  rstn,
	wb_if.slave   up,
	wb_if.master  down
);

	logic [wb_pkg::WDOG_CNT_W-1:0] cnt;
	logic                          hold;
	logic                          active;
	logic                          timeout;

	assign active  = up.cyc && up.stb && !hold;
	assign timeout = active && !down.ack && !down.err && (cnt == wb_pkg::WDOG_LIMIT);

	assign down.adr   = up.adr;
	assign down.dat_w = up.dat_w;
	assign down.sel   = up.sel;
	assign down.we    = up.we;
	assign down.cyc   = up.cyc;
	// Slave stays idle after a timeout until the master lets go
	assign down.stb   = up.stb && !hold;

	assign up.dat_r = down.dat_r;
	assign up.ack   = down.ack;
	assign up.err   = down.err || timeout;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			cnt  <= '0;
			hold <= 1'b0;
		end else begin
			if (!up.stb) begin
				hold <= 1'b0;
			end else if (timeout) begin
				hold <= 1'b1;
			end
			if (!active || down.ack || down.err) begin
				cnt <= '0;
			end else if (cnt != wb_pkg::WDOG_LIMIT) begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

/* hdl/wb_pkg.sv */
// ------------------------------
// Wishbone subsystem package
// Bus widths, address map and timing constants
// Address word layout
// ------------------------------
package wb_pkg;

	localparam int WB_ADDR_W = 32;
	localparam int WB_DATA_W = 32;
	localparam int WB_SEL_W  = 4;

	localparam int N_MASTERS = 3;
	localparam int N_SLAVES  = 2;

	// Region is taken from the top address bits
	localparam int REGION_W = 4;
	localparam logic [REGION_W-1:0] REGION_SRAM = REGION_W'(0);
	localparam logic [REGION_W-1:0] REGION_REGS = REGION_W'(1);

	localparam int SRAM_WORDS = 64;

	// Extra cycles the register block waits before it acknowledges
	localparam int REG_WAIT_W = 2;
	localparam logic [REG_WAIT_W-1:0] REG_WAIT = REG_WAIT_W'(2);

	// Cycles without acknowledge before a link is ended with ERR
	localparam int WDOG_CNT_W = 5;
	localparam logic [WDOG_CNT_W-1:0] WDOG_LIMIT = WDOG_CNT_W'(16);

	// Control register reset values, index 3 down to 0
	localparam logic [3:0][WB_DATA_W-1:0] CTRL_RESET = {
		32'h1234_5678,
		32'h0000_00ff,
		32'ha5a5_0000,
		32'h0000_0001
	};

	typedef union packed {
		logic [WB_ADDR_W-1:0] raw;
		struct packed {
			logic [REGION_W-1:0] region;
			logic [25:0]         word_idx;
			logic [1:0]          byte_off;
		} fields;
	} wb_addr_u;

endpackage

/* hdl/wb_sram.sv */
// ------------------------------
// Wishbone SRAM slave
// Byte-select writes, registered acknowledge
// ------------------------------
`timescale 1ns/100ps

module wb_sram (
	input  logic  clk,
	input  logic  rstn,
	wb_if.slave   bus
);

	logic [wb_pkg::WB_DATA_W-1:0]          mem [wb_pkg::SRAM_WORDS];
	wb_pkg::wb_addr_u                      adr_w;
	logic [$clog2(wb_pkg::SRAM_WORDS)-1:0] idx;
	logic                                  req;

	assign adr_w.raw = bus.adr;
	assign idx       = adr_w.fields.word_idx[$clog2(wb_pkg::SRAM_WORDS)-1:0];
	// One access per strobe, the ack cycle itself is not a new request
	assign req       = bus.cyc && bus.stb && !bus.ack;

	assign bus.err = 1'b0;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			bus.ack <= 1'b0;
		end else begin
			bus.ack <= req;
		end
	end

	always_ff @(posedge clk) begin
		if (req) begin
			if (bus.we) begin
				for (int b = 0; b < wb_pkg::WB_SEL_W; b++) begin
					if (bus.sel[b]) begin
						mem[idx][8*b +: 8] <= bus.dat_w[8*b +: 8];
					end
				end
			end
			bus.dat_r <= mem[idx];
		end
	end

endmodule

/* hdl/wb_subsys_top.sv */
// ------------------------------
// Wishbone subsystem top level
// Crossbar, link watchdogs, SRAM and register block
// ------------------------------
`timescale 1ns/100ps

module wb_subsys_top (
	input  logic                         clk,
	input  logic                         rstn,
	input  logic [wb_pkg::WB_ADDR_W-1:0] m_adr_i   [wb_pkg::N_MASTERS],
	input  logic [wb_pkg::WB_DATA_W-1:0] m_dat_w_i [wb_pkg::N_MASTERS],
	input  logic [wb_pkg::WB_SEL_W-1:0]  m_sel_i   [wb_pkg::N_MASTERS],
	input  logic                         m_we_i    [wb_pkg::N_MASTERS],
	input  logic                         m_cyc_i   [wb_pkg::N_MASTERS],
	input  logic                         m_stb_i   [wb_pkg::N_MASTERS],
	output logic [wb_pkg::WB_DATA_W-1:0] m_dat_r_o [wb_pkg::N_MASTERS],
	output logic                         m_ack_o   [wb_pkg::N_MASTERS],
	output logic                         m_err_o   [wb_pkg::N_MASTERS]
);

	// Crossbar side and slave side of each link
	wb_if xb_s0 ();
	wb_if xb_s1 ();
	wb_if sram_bus ();
	wb_if regs_bus ();

	wb_crossbar u_xbar (
		.clk       (clk),
		.rstn      (rstn),
		.m_adr_i   (m_adr_i),
		.m_dat_w_i (m_dat_w_i),
		.m_sel_i   (m_sel_i),
		.m_we_i    (m_we_i),
		.m_cyc_i   (m_cyc_i),
		.m_stb_i   (m_stb_i),
		.m_dat_r_o (m_dat_r_o),
		.m_ack_o   (m_ack_o),
		.m_err_o   (m_err_o),
		.s0        (xb_s0.master),
		.s1        (xb_s1.master)
	);

	wb_link_watchdog u_wdog0 (
		.clk  (clk),
		.rstn (rstn),
		.up   (xb_s0.slave),
		.down (sram_bus.master)
	);

	wb_link_watchdog u_wdog1 (
		.clk  (clk),
		.rstn (rstn),
		.up   (xb_s1.slave),
		.down (regs_bus.master)
	);

	wb_sram u_sram (
		.clk  (clk),
		.rstn (rstn),
		.bus  (sram_bus.slave)
	);

	wb_ctrl_regs u_regs (
		.clk  (clk),
		.rstn (rstn),
		.bus  (regs_bus.slave)
	);

endmodule

/* sim.f */
hdl/wb_pkg.sv
hdl/wb_if.sv
hdl/wb_arbiter.sv
hdl/wb_link_watchdog.sv
hdl/wb_sram.sv
hdl/wb_ctrl_regs.sv
hdl/wb_crossbar.sv
hdl/wb_subsys_top.sv
verif/wb_subsys_asserts.sv
verif/wb_subsys_tb.sv

/* verif/wb_subsys_asserts.sv */
// ------------------------------
// Crossbar protocol assertions
// Bound into the crossbar
// ------------------------------
`timescale 1ns/100ps

module wb_subsys_asserts (
	input logic                                 clk,
	input logic                                 rstn,
	input logic                                 m_stb_i     [wb_pkg::N_MASTERS],
	input logic                                 m_ack_o     [wb_pkg::N_MASTERS],
	input logic                                 m_err_o     [wb_pkg::N_MASTERS],
	input logic                                 p_stb       [wb_pkg::N_SLAVES+1],
	input logic [wb_pkg::N_MASTERS-1:0]         port_req    [wb_pkg::N_SLAVES+1],
	input logic [$clog2(wb_pkg::N_MASTERS)-1:0] port_gnt_id [wb_pkg::N_SLAVES+1]
);

	for (genvar m = 0; m < wb_pkg::N_MASTERS; m++) begin : g_master
		ack_err_excl: assert property (@(posedge clk) disable iff (!rstn)
			!(m_ack_o[m] && m_err_o[m]))
			else $error("Master %0d got ack and err in the same cycle", m);
		ack_needs_stb: assert property (@(posedge clk) disable iff (!rstn)
			m_ack_o[m] |-> m_stb_i[m])
			else $error("Master %0d got ack while its stb was low", m);
	end

	// A strobe on a port must come from the one master that holds its grant and targets it
	for (genvar p = 0; p <= wb_pkg::N_SLAVES; p++) begin : g_port
		stb_owner: assert property (@(posedge clk) disable iff (!rstn)
			p_stb[p] |-> port_req[p][port_gnt_id[p]])
			else $error("Port %0d strobed by a master that does not own it", p);
	end

endmodule

bind wb_crossbar wb_subsys_asserts u_asserts (
	.clk         (clk),
	.rstn        (rstn),
	.m_stb_i     (m_stb_i),
	.m_ack_o     (m_ack_o),
	.m_err_o     (m_err_o),
	.p_stb       (p_stb),
	.port_req    (port_req),
	.port_gnt_id (port_gnt_id)
);

/* verif/wb_subsys_tb.sv */
// ------------------------------
// Wishbone subsystem testbench
// Clock, reset, timeout and bus tasks
// Compare tasks and directed tests
// ------------------------------
`timescale 1ns/100ps

module wb_subsys_tb;

	// Five tests, up to about 60 accesses of up to about 20 cycles, with margin
	localparam int MAX_CYCLES = 2000;

	logic                         clk = 1'b0;
	logic                         rstn;
	logic [wb_pkg::WB_ADDR_W-1:0] m_adr   [wb_pkg::N_MASTERS];
	logic [wb_pkg::WB_DATA_W-1:0] m_dat_w [wb_pkg::N_MASTERS];
	logic [wb_pkg::WB_SEL_W-1:0]  m_sel   [wb_pkg::N_MASTERS];
	logic                         m_we    [wb_pkg::N_MASTERS];
	logic                         m_cyc   [wb_pkg::N_MASTERS];
	logic                         m_stb   [wb_pkg::N_MASTERS];
	logic [wb_pkg::WB_DATA_W-1:0] m_dat_r [wb_pkg::N_MASTERS];
	logic                         m_ack   [wb_pkg::N_MASTERS];
	logic                         m_err   [wb_pkg::N_MASTERS];

	// Expected SRAM contents, built from the writes
	logic [wb_pkg::WB_DATA_W-1:0] sram_model [wb_pkg::SRAM_WORDS];
	logic [wb_pkg::WB_DATA_W-1:0] race_data  [wb_pkg::N_MASTERS];
	int                           ack_order  [$];
	int                           cycle_cnt = 0;

	wb_subsys_top uut (
		.clk       (clk),
		.rstn      (rstn),
		.m_adr_i   (m_adr),
		.m_dat_w_i (m_dat_w),
		.m_sel_i   (m_sel),
		.m_we_i    (m_we),
		.m_cyc_i   (m_cyc),
		.m_stb_i   (m_stb),
		.m_dat_r_o (m_dat_r),
		.m_ack_o   (m_ack),
		.m_err_o   (m_err)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == MAX_CYCLES) begin
			fail_run("Timeout: the tests did not finish within the cycle limit");
		end
	end

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("** FAIL **");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_data(input string test, input logic [wb_pkg::WB_DATA_W-1:0] exp,
			input logic [wb_pkg::WB_DATA_W-1:0] act);
		if (act !== exp) begin
			fail_run($sformatf("FAILED %s: expected %h, actual %h", test, exp, act));
		end
	endtask

	task automatic check_err(input string test, input logic exp, input logic act);
		if (act !== exp) begin
			fail_run($sformatf("FAILED %s: expected err %b, actual err %b", test, exp, act));
		end
	endtask

	task automatic check_latency(input string test, input int min_cycles, input int act);
		if (act < min_cycles) begin
			fail_run($sformatf("FAILED %s: expected at least %0d cycles, actual %0d",
				test, min_cycles, act));
		end
	endtask

	task automatic check_id(input string test, input int exp, input int act);
		if (act != exp) begin
			fail_run($sformatf("FAILED %s: expected master %0d, actual master %0d",
				test, exp, act));
		end
	endtask

	function automatic logic [wb_pkg::WB_ADDR_W-1:0] word_addr(input logic [3:0] region,
			input int idx);
		return {region, idx[25:0], 2'b00};
	endfunction

	// Bytes with sel set take the new data, the rest keep the old word
	function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
			input logic [31:0] new_w, input logic [3:0] sel);
		logic [31:0] res;
		res = old_w;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				res[8*b +: 8] = new_w[8*b +: 8];
			end
		end
		return res;
	endfunction

	task automatic apply_reset();
		@(posedge clk);
		rstn <= 1'b0;
		repeat (5) @(posedge clk);
		rstn <= 1'b1;
	endtask

	// One classic cycle, latency counted from the cycle stb rises
	task automatic bus_cycle(input int m, input logic we, input logic [31:0] adr,
			input logic [31:0] dat, input logic [3:0] sel, output logic [31:0] rdata,
			output logic err, output int lat);
		@(posedge clk);
		m_adr[m]   <= adr;
		m_dat_w[m] <= dat;
		m_sel[m]   <= sel;
		m_we[m]    <= we;
		m_cyc[m]   <= 1'b1;
		m_stb[m]   <= 1'b1;
		lat = 0;
		@(negedge clk);
		while (!m_ack[m] && !m_err[m]) begin
			@(negedge clk);
			lat++;
		end
		rdata = m_dat_r[m];
		err   = m_err[m];
		@(posedge clk);
		m_cyc[m] <= 1'b0;
		m_stb[m] <= 1'b0;
	endtask

	task automatic wb_write(input int m, input logic [31:0] adr, input logic [31:0] dat,
			input logic [3:0] sel, output logic err, output int lat);
		logic [31:0] unused;
		bus_cycle(m, 1'b1, adr, dat, sel, unused, err, lat);
	endtask

	task automatic wb_read(input int m, input logic [31:0] adr, output logic [31:0] data,
			output logic err, output int lat);
		bus_cycle(m, 1'b0, adr, 32'h0, 4'hf, data, err, lat);
	endtask

	task automatic test_sram_rw();
		logic [31:0] data;
		logic [31:0] rdata;
		logic [3:0]  sel;
		logic        err;
		int          lat;
		int          idx;
		// Full words first so that partial writes merge into known contents
		for (int i = 0; i < 12; i++) begin
			idx  = i * 5;
			data = $urandom;
			wb_write(i % 3, word_addr(wb_pkg::REGION_SRAM, idx), data, 4'hf, err, lat);
			check_err("sram_rw", 1'b0, err);
			sram_model[idx] = data;
		end
		for (int i = 0; i < 12; i++) begin
			idx  = i * 5;
			sel  = 4'(i + 1);
			data = $urandom;
			wb_write((i + 1) % 3, word_addr(wb_pkg::REGION_SRAM, idx), data, sel, err, lat);
			check_err("sram_rw", 1'b0, err);
			sram_model[idx] = merge_bytes(sram_model[idx], data, sel);
		end
		for (int i = 0; i < 12; i++) begin
			idx = i * 5;
			wb_read((i + 2) % 3, word_addr(wb_pkg::REGION_SRAM, idx), rdata, err, lat);
			check_err("sram_rw", 1'b0, err);
			check_data("sram_rw", sram_model[idx], rdata);
			check_latency("sram_rw", 3, lat);
		end
	endtask

	task automatic test_regs();
		logic [31:0] rdata;
		logic        err;
		int          lat;
		for (int i = 0; i < 4; i++) begin
			wb_read(i % 3, word_addr(wb_pkg::REGION_REGS, i), rdata, err, lat);
			check_err("regs_reset", 1'b0, err);
			check_data("regs_reset", wb_pkg::CTRL_RESET[i], rdata);
			check_latency("regs_reset", int'(wb_pkg::REG_WAIT) + 3, lat);
		end
		for (int i = 0; i < 4; i++) begin
			wb_write((i + 1) % 3, word_addr(wb_pkg::REGION_REGS, i), 32'hc0de_0000 + i,
				4'hf, err, lat);
			check_err("regs_write", 1'b0, err);
			check_latency("regs_write", int'(wb_pkg::REG_WAIT) + 3, lat);
		end
		for (int i = 0; i < 4; i++) begin
			wb_read((i + 2) % 3, word_addr(wb_pkg::REGION_REGS, i), rdata, err, lat);
			check_err("regs_read", 1'b0, err);
			check_data("regs_read", 32'hc0de_0000 + i, rdata);
		end
	endtask

	task automatic test_decode_err();
		logic [31:0] rdata;
		logic        err;
		int          lat;
		wb_read(1, word_addr(4'h2, 3), rdata, err, lat);
		check_err("decode_err", 1'b1, err);
		wb_write(2, word_addr(4'hf, 0), 32'h0, 4'hf, err, lat);
		check_err("decode_err", 1'b1, err);
		// SRAM right after the error
		wb_write(1, word_addr(wb_pkg::REGION_SRAM, 63), 32'hdead_beef, 4'hf, err, lat);
		check_err("decode_err_sram", 1'b0, err);
		sram_model[63] = 32'hdead_beef;
		wb_read(1, word_addr(wb_pkg::REGION_SRAM, 63), rdata, err, lat);
		check_err("decode_err_sram", 1'b0, err);
		check_data("decode_err_sram", sram_model[63], rdata);
	endtask

	task automatic test_watchdog();
		logic [31:0] rdata;
		logic        err;
		int          lat;
		wb_read(0, word_addr(wb_pkg::REGION_REGS, 5), rdata, err, lat);
		check_err("watchdog", 1'b1, err);
		check_latency("watchdog", int'(wb_pkg::WDOG_LIMIT), lat);
		wb_read(0, word_addr(wb_pkg::REGION_REGS, 2), rdata, err, lat);
		check_err("watchdog_after", 1'b0, err);
		check_data("watchdog_after", 32'hc0de_0002, rdata);
	endtask

	task automatic contend_write(input int m);
		logic err;
		int   lat;
		wb_write(m, word_addr(wb_pkg::REGION_SRAM, 40 + m), race_data[m], 4'hf, err, lat);
		check_err("contention", 1'b0, err);
		ack_order.push_back(m);
	endtask

	task automatic test_contention();
		logic [31:0] rdata;
		logic        err;
		int          lat;
		// Fresh arbiters, so the first grant goes to master 0
		apply_reset();
		for (int m = 0; m < wb_pkg::N_MASTERS; m++) begin
			race_data[m] = $urandom;
		end
		ack_order.delete();
		fork
			contend_write(0);
			contend_write(1);
			contend_write(2);
		join
		check_id("contention_count", 3, ack_order.size());
		for (int m = 0; m < wb_pkg::N_MASTERS; m++) begin
			check_id("contention_order", m, ack_order[m]);
			sram_model[40 + m] = race_data[m];
		end
		for (int m = 0; m < wb_pkg::N_MASTERS; m++) begin
			wb_read(m, word_addr(wb_pkg::REGION_SRAM, 40 + m), rdata, err, lat);
			check_err("contention_read", 1'b0, err);
			check_data("contention_read", sram_model[40 + m], rdata);
		end
	endtask

	initial begin
		rstn = 1'b0;
		for (int m = 0; m < wb_pkg::N_MASTERS; m++) begin
			m_adr[m]   = '0;
			m_dat_w[m] = '0;
			m_sel[m]   = '0;
			m_we[m]    = 1'b0;
			m_cyc[m]   = 1'b0;
			m_stb[m]   = 1'b0;
		end
		void'($urandom(32'hbac42be2));
		apply_reset();
		test_sram_rw();
		test_regs();
		test_decode_err();
		test_watchdog();
		test_contention();
		$display("** PASS **");
		$finish;
	end

endmodule
